//--- aes_config.svh
`ifndef AES_CONFIG_SVH
`define AES_CONFIG_SVH

// Cipher rounds for a 128-bit key.
`define AES_ROUNDS 10

// One state or round key.
`define AES_BLOCK_BITS 128

// One state column.
`define AES_WORD_BITS 32

// Whitening register plus two cycles per round.
`define AES_LATENCY 21

`endif

//--- aes_pkg.sv
`include "aes_config.svh"

package aes_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [`AES_WORD_BITS-1:0] word_t;
  typedef logic [`AES_BLOCK_BITS-1:0] block_t;

  // ############################
  // Forward substitution table
  // ############################

  localparam byte_t SBOX [256] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  // ############################
  // Field helpers
  // ############################

  // Multiply by x modulo x^8 + x^4 + x^3 + x + 1.
  function automatic byte_t xtime(byte_t b);
    byte_t r;
    r = {b[6:0], 1'b0};
    if (b[7])
    begin
      r = r ^ 8'h1b; // Reduce the carried-out bit.
    end
    return r;
  endfunction

  // The round constant for rounds 1 to 10 is a successive power of x.
  function automatic byte_t rcon_of(int idx);
    byte_t rc;
    rc = 8'h01;
    for (int i = 1; i < idx; i++)
    begin
      rc = xtime(rc);
    end
    return rc;
  endfunction

endpackage

//--- aes_sub_word.sv
`timescale 1ns/1ps

module aes_sub_word (
  input  logic           clk,
  input  aes_pkg::word_t word_in,
  output aes_pkg::word_t word_out
);

  import aes_pkg::*;

  byte_t sub_q [4];

  // Each byte has its own lookup register, so the word lags its input by one cycle.
  always_ff @(posedge clk)
  begin
    for (int i = 0; i < 4; i++)
    begin
      sub_q[i] <= SBOX[word_in[31 - 8*i -: 8]];
    end
  end

  assign word_out = {sub_q[0], sub_q[1], sub_q[2], sub_q[3]}; // Byte 0 sits at the top.

endmodule

//--- aes_round.sv
`timescale 1ns/1ps

module aes_round #(
  parameter int last_round = 0
) (
  input  logic            clk,
  input  aes_pkg::block_t state_in,
  input  aes_pkg::block_t round_key,
  output aes_pkg::block_t state_out
);

  import aes_pkg::*;

  byte_t s_q [16];
  word_t col [4];

  // ############################
  // Byte lookups in cycle 1
  // ############################

  // State byte n sits at bits 127-8n in the column-major order of FIPS-197.
  always_ff @(posedge clk)
  begin
    for (int n = 0; n < 16; n++)
    begin
      s_q[n] <= SBOX[state_in[127 - 8*n -: 8]];
    end
  end

  // ############################
  // Column forming in cycle 2
  // ############################

  if (last_round == 0)
  begin : g_full
    byte_t d_q [16];

    always_ff @(posedge clk)
    begin
      for (int n = 0; n < 16; n++)
      begin
        d_q[n] <= xtime(SBOX[state_in[127 - 8*n -: 8]]); // Doubled S-box value.
      end
    end

    // The table word {S, S, 3S, 2S} is rotated so that 2S lands on the byte's own row.
    always_comb
    begin
      int j;
      word_t tw;
      logic [63:0] dbl;
      for (int c = 0; c < 4; c++)
      begin
        col[c] = '0;
        for (int r = 0; r < 4; r++)
        begin
          j = 4 * ((c + r) % 4) + r; // Row r is shifted left by r columns.
          tw = {s_q[j], s_q[j], s_q[j] ^ d_q[j], d_q[j]};
          dbl = {tw, tw} >> (8 * ((r + 1) % 4));
          col[c] = col[c] ^ dbl[31:0];
        end
      end
    end
  end
  else
  begin : g_final
    // The final round only shifts the rows and mixes no columns.
    always_comb
    begin
      for (int c = 0; c < 4; c++)
      begin
        col[c] = {s_q[4 * (c % 4)],
                  s_q[4 * ((c + 1) % 4) + 1],
                  s_q[4 * ((c + 2) % 4) + 2],
                  s_q[4 * ((c + 3) % 4) + 3]};
      end
    end
  end

  always_ff @(posedge clk)
  begin
    for (int c = 0; c < 4; c++)
    begin
      state_out[127 - 32*c -: 32] <= col[c] ^ round_key[127 - 32*c -: 32];
    end
  end

  // A known state followed by its known key gives a known result.
  a_known_out : assert property (
    @(posedge clk)
    !$isunknown(state_in) ##1 !$isunknown(round_key) |=> !$isunknown(state_out)
  ) else $error("aes_round: unknown output from known state and key");

endmodule

//--- aes_key_stage.sv
`timescale 1ns/1ps

module aes_key_stage #(
  parameter int round_index = 1
) (
  input  logic            clk,
  input  aes_pkg::block_t key_in,
  output aes_pkg::block_t key_next,
  output aes_pkg::block_t round_key
);

  import aes_pkg::*;

  localparam byte_t RCON = rcon_of(round_index);

  word_t w [4];
  word_t v [4];
  word_t v_q [4];
  word_t rot_w;
  word_t sub_w;

  for (genvar i = 0; i < 4; i++)
  begin : g_split
    assign w[i] = key_in[127 - 32*i -: 32];
  end

  // XOR chain across the four words with the round constant in the first.
  assign v[0] = w[0] ^ {RCON, 24'h000000};
  assign v[1] = v[0] ^ w[1];
  assign v[2] = v[1] ^ w[2];
  assign v[3] = v[2] ^ w[3];

  always_ff @(posedge clk)
  begin
    v_q <= v;
  end

  assign rot_w = {w[3][23:0], w[3][31:24]}; // RotWord on the last word.

  aes_sub_word u_sub_word (
    .clk      (clk),
    .word_in  (rot_w),
    .word_out (sub_w)
  );

  // The substituted word folds into every word, since the chain already carries it forward.
  assign round_key = {v_q[0] ^ sub_w, v_q[1] ^ sub_w, v_q[2] ^ sub_w, v_q[3] ^ sub_w};

  always_ff @(posedge clk)
  begin
    key_next <= round_key;
  end

endmodule

//--- aes_128_pipe.sv
`timescale 1ns/1ps
`include "aes_config.svh"

module aes_128_pipe (
  input  logic            clk,
  input  logic            rst,
  input  logic            in_valid,
  input  aes_pkg::block_t plaintext,
  input  aes_pkg::block_t key,
  output logic            out_valid,
  output aes_pkg::block_t ciphertext
);

  import aes_pkg::*;

  block_t state_chain [`AES_ROUNDS + 1];
  block_t key_chain [`AES_ROUNDS + 1];
  block_t rkey [`AES_ROUNDS];

  logic [`AES_LATENCY-1:0] valid_sr;

  // ############################
  // Initial key whitening
  // ############################

  always_ff @(posedge clk)
  begin
    state_chain[0] <= plaintext ^ key;
    key_chain[0] <= key; // Raw key starts the expansion.
  end

  // ############################
  // Round and key chains
  // ############################

  for (genvar r = 0; r < `AES_ROUNDS; r++)
  begin : g_stage
    aes_key_stage #(
      .round_index (r + 1)
    ) u_key_stage (
      .clk       (clk),
      .key_in    (key_chain[r]),
      .key_next  (key_chain[r + 1]),
      .round_key (rkey[r])
    );

    aes_round #(
      .last_round (r == `AES_ROUNDS - 1)
    ) u_round (
      .clk       (clk),
      .state_in  (state_chain[r]),
      .round_key (rkey[r]),
      .state_out (state_chain[r + 1])
    );
  end

  assign ciphertext = state_chain[`AES_ROUNDS];

  // ############################
  // Valid pipeline
  // ############################

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_sr <= '0;
    end
    else
    begin
      valid_sr <= {valid_sr[`AES_LATENCY-2:0], in_valid};
    end
  end

  assign out_valid = valid_sr[`AES_LATENCY-1];

  // Accepted blocks and gaps reach the output after the full data path latency.
  a_valid_taken : assert property (
    @(posedge clk) disable iff (rst)
    in_valid |-> ##(`AES_LATENCY) out_valid
  ) else $error("aes_128_pipe: accepted block missing at output");

  a_valid_gap : assert property (
    @(posedge clk) disable iff (rst)
    !in_valid |-> ##(`AES_LATENCY) !out_valid
  ) else $error("aes_128_pipe: output valid without an accepted block");

  a_valid_known : assert property (
    @(posedge clk) disable iff (rst)
    !$isunknown(out_valid)
  ) else $error("aes_128_pipe: out_valid unknown after reset");

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns period.
  end

  initial
  begin
    rst = 1'b1;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst <= 1'b0;
  end

endmodule

//--- tb_aes_model.svh
`ifndef TB_AES_MODEL_SVH
`define TB_AES_MODEL_SVH

// Multiplication by two in GF(2^8).
function automatic byte_t gf_double(byte_t b);
  byte_t r;
  r = {b[6:0], 1'b0};
  if (b[7])
  begin
    r = r ^ 8'h1b;
  end
  return r;
endfunction

// One step of the AES-128 key schedule.
function automatic block_t next_key(block_t k, byte_t rc);
  word_t w0;
  word_t w1;
  word_t w2;
  word_t w3;
  word_t t;
  w0 = k[127:96];
  w1 = k[95:64];
  w2 = k[63:32];
  w3 = k[31:0];
  t = {w3[23:0], w3[31:24]};
  t = {SBOX[t[31:24]], SBOX[t[23:16]], SBOX[t[15:8]], SBOX[t[7:0]]} ^ {rc, 24'h000000};
  w0 = w0 ^ t;
  w1 = w1 ^ w0;
  w2 = w2 ^ w1;
  w3 = w3 ^ w2;
  return {w0, w1, w2, w3};
endfunction

// Straight FIPS-197 cipher with state byte (row r, column c) at index 4c + r.
function automatic block_t aes_encrypt(block_t blk_key, block_t blk_pt);
  byte_t st [16];
  byte_t sh [16];
  byte_t a0;
  byte_t a1;
  byte_t a2;
  byte_t a3;
  block_t rk;
  block_t res;
  byte_t rc;
  rk = blk_key;
  rc = 8'h01;
  for (int n = 0; n < 16; n++)
  begin
    st[n] = blk_pt[127 - 8*n -: 8] ^ blk_key[127 - 8*n -: 8];
  end
  for (int round = 1; round <= `AES_ROUNDS; round++)
  begin
    rk = next_key(rk, rc);
    rc = gf_double(rc);
    for (int c = 0; c < 4; c++)
    begin
      for (int r = 0; r < 4; r++)
      begin
        sh[4*c + r] = SBOX[st[4*((c + r) % 4) + r]]; // SubBytes then ShiftRows.
      end
    end
    for (int c = 0; c < 4; c++)
    begin
      a0 = sh[4*c];
      a1 = sh[4*c + 1];
      a2 = sh[4*c + 2];
      a3 = sh[4*c + 3];
      if (round < `AES_ROUNDS)
      begin
        st[4*c]     = gf_double(a0) ^ gf_double(a1) ^ a1 ^ a2 ^ a3;
        st[4*c + 1] = a0 ^ gf_double(a1) ^ gf_double(a2) ^ a2 ^ a3;
        st[4*c + 2] = a0 ^ a1 ^ gf_double(a2) ^ gf_double(a3) ^ a3;
        st[4*c + 3] = gf_double(a0) ^ a0 ^ a1 ^ a2 ^ gf_double(a3);
      end
      else
      begin
        st[4*c]     = a0; // No MixColumns in the last round.
        st[4*c + 1] = a1;
        st[4*c + 2] = a2;
        st[4*c + 3] = a3;
      end
    end
    for (int n = 0; n < 16; n++)
    begin
      st[n] = st[n] ^ rk[127 - 8*n -: 8];
    end
  end
  for (int n = 0; n < 16; n++)
  begin
    res[127 - 8*n -: 8] = st[n];
  end
  return res;
endfunction

`endif

//--- tb_aes_128_pipe.sv
`timescale 1ns/1ps
`include "aes_config.svh"

module tb_aes_128_pipe;

  import aes_pkg::*;

  `include "tb_aes_model.svh"

  localparam int TIMEOUT_CYCLES = 2000;

  logic   clk;
  logic   rst;
  logic   in_valid;
  block_t plaintext;
  block_t key;
  logic   out_valid;
  block_t ciphertext;

  block_t exp_q [$];
  block_t exp_head;
  logic   exp_present;
  int     accepted_count;
  int     checked_count;
  int     error_count;
  int     tests_run;
  int     tests_passed;
  int     cycle_count;

  tb_clock_gen u_clock_gen (
    .clk (clk),
    .rst (rst)
  );

  aes_128_pipe DUT (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .plaintext  (plaintext),
    .key        (key),
    .out_valid  (out_valid),
    .ciphertext (ciphertext)
  );

  // ##############################
  // Checking
  // ##############################

  // The head is loaded on the falling edge, ahead of the rising edge that checks it.
  always @(negedge clk)
  begin
    if (!rst && out_valid)
    begin
      if (exp_q.size() > 0)
      begin
        exp_head = exp_q.pop_front();
        exp_present = 1'b1;
      end
      else
      begin
        exp_present = 1'b0;
      end
      checked_count++;
    end
  end

  a_data_match : assert property (
    @(posedge clk) disable iff (rst)
    out_valid |-> (exp_present && ciphertext == exp_head)
  ) else
  begin
    error_count++;
    $display("[FAIL] %0t: ciphertext %h, expected %h (expectation present %b)",
             $time, $sampled(ciphertext), $sampled(exp_head), $sampled(exp_present));
  end

  a_valid_delay : assert property (
    @(posedge clk) disable iff (rst)
    (cycle_count > `AES_LATENCY) |-> (out_valid == $past(in_valid, `AES_LATENCY))
  ) else
  begin
    error_count++;
    $display("[FAIL] %0t: out_valid %b does not match in_valid of %0d cycles earlier",
             $time, $sampled(out_valid), `AES_LATENCY);
  end

  a_idle_after_reset : assert property (
    @(posedge clk) disable iff (rst)
    (accepted_count == 0) |-> !out_valid
  ) else
  begin
    error_count++;
    $display("[FAIL] %0t: out_valid high before any block was accepted", $time);
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES)
    begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  // ##############################
  // Stimulus helpers
  // ##############################

  task automatic send_block(block_t blk_key, block_t blk_pt, block_t expected);
    in_valid = 1'b1;
    key = blk_key;
    plaintext = blk_pt;
    exp_q.push_back(expected);
    accepted_count++;
    @(negedge clk);
  endtask

  // Sends a known answer vector after holding it against the model.
  task automatic send_known(block_t blk_key, block_t blk_pt, block_t expected);
    a_model_vector : assert (aes_encrypt(blk_key, blk_pt) == expected) else
    begin
      error_count++;
      $display("[FAIL] %0t: model gives %h, expected %h",
               $time, aes_encrypt(blk_key, blk_pt), expected);
    end
    send_block(blk_key, blk_pt, expected);
  endtask

  task automatic send_random();
    block_t k;
    block_t pt;
    k = {$urandom, $urandom, $urandom, $urandom};
    pt = {$urandom, $urandom, $urandom, $urandom};
    send_block(k, pt, aes_encrypt(k, pt));
  endtask

  task automatic idle_cycles(int n);
    in_valid = 1'b0;
    repeat (n) @(negedge clk);
  endtask

  // Waits until every accepted block has left and the edge that checks the last one has passed.
  task automatic wait_drain();
    in_valid = 1'b0;
    while (checked_count != accepted_count)
    begin
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  task automatic report_test(string name, int errors_before);
    tests_run++;
    if (error_count == errors_before)
    begin
      tests_passed++;
      $display("test %-22s passed", name);
    end
    else
    begin
      $display("test %-22s failed with %0d errors", name, error_count - errors_before);
    end
  endtask

  // ##############################
  // Test sequence
  // ##############################

  initial
  begin
    int errs;
    void'($urandom(32'h4cc6));
    in_valid = 1'b0;
    plaintext = '0;
    key = '0;
    exp_head = '0;
    exp_present = 1'b0;
    accepted_count = 0;
    checked_count = 0;
    error_count = 0;
    tests_run = 0;
    tests_passed = 0;
    cycle_count = 0;

    errs = error_count;
    @(negedge clk);
    while (rst)
    begin
      @(negedge clk);
    end
    idle_cycles(`AES_LATENCY + 4);
    report_test("reset_idle", errs);

    errs = error_count;
    send_known(128'h000102030405060708090a0b0c0d0e0f, 128'h00112233445566778899aabbccddeeff,
               128'h69c4e0d86a7b0430d8cdb78070b4c55a);
    wait_drain();
    report_test("fips_appendix_c", errs);

    errs = error_count;
    send_known(128'h2b7e151628aed2a6abf7158809cf4f3c, 128'h3243f6a8885a308d313198a2e0370734,
               128'h3925841d02dc09fbdc118597196a0b32);
    send_known(128'h0, 128'h0, 128'h66e94bd4ef8a2c3b884cfa59ca342b2e);
    wait_drain();
    report_test("fips_appendix_b_zero", errs);

    errs = error_count;
    repeat (64) send_random();
    wait_drain();
    report_test("random_back_to_back", errs);

    errs = error_count;
    repeat (64)
    begin
      idle_cycles($urandom_range(0, 3));
      send_random();
    end
    wait_drain();
    report_test("random_with_gaps", errs);

    $display("Summary: %0d of %0d tests passed, %0d outputs checked, %0d errors",
             tests_passed, tests_run, checked_count, error_count);
    if (error_count == 0 && tests_passed == tests_run)
    begin
      $display("TEST PASS");
    end
    else
    begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- aes_128_pipe.f
+incdir+.
aes_pkg.sv
aes_sub_word.sv
aes_round.sv
aes_key_stage.sv
aes_128_pipe.sv
tb_clock_gen.sv
tb_aes_128_pipe.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the AES-128 pipeline testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_aes_128_pipe \
  -f aes_128_pipe.f \
  -o sim_aes_128_pipe

./obj_dir/sim_aes_128_pipe 2>&1 | tee sim.log

if grep -q "^TEST PASS$" sim.log; then
  echo "run_sim: simulation passed"
  exit 0
fi
echo "run_sim: simulation failed, see sim.log"
exit 1
